// ==== src/cpu_pkg.sv ====
package cpu_pkg;

  localparam int unsigned data_width = 8;
  localparam int unsigned addr_width = 16;

  // Supported 6502 opcodes
  localparam logic [data_width-1:0] op_nop     = 8'hEA;
  localparam logic [data_width-1:0] op_lda_imm = 8'hA9;
  localparam logic [data_width-1:0] op_lda_zp  = 8'hA5;
  localparam logic [data_width-1:0] op_lda_zpx = 8'hB5;
  localparam logic [data_width-1:0] op_ldx_imm = 8'hA2;
  localparam logic [data_width-1:0] op_ldx_zp  = 8'hA6;
  localparam logic [data_width-1:0] op_adc_imm = 8'h69;
  localparam logic [data_width-1:0] op_sta_zp  = 8'h85;
  localparam logic [data_width-1:0] op_jmp_abs = 8'h4C;

  // Sequencer stages
  localparam int unsigned stage_width = 3;
  localparam logic [stage_width-1:0] stage_fetch       = 3'd0;
  localparam logic [stage_width-1:0] stage_operand     = 3'd1;
  localparam logic [stage_width-1:0] stage_access      = 3'd2;
  localparam logic [stage_width-1:0] stage_finish      = 3'd3;
  localparam logic [stage_width-1:0] stage_vector_low  = 3'd6;
  localparam logic [stage_width-1:0] stage_vector_high = 3'd7;

  // Next-address selection
  localparam int unsigned addr_src_width = 3;
  localparam logic [addr_src_width-1:0] addr_src_keep        = 3'd0;
  localparam logic [addr_src_width-1:0] addr_src_pc_next     = 3'd1;
  localparam logic [addr_src_width-1:0] addr_src_zp_data     = 3'd2;
  localparam logic [addr_src_width-1:0] addr_src_zp_hold     = 3'd3;
  localparam logic [addr_src_width-1:0] addr_src_vector_high = 3'd4;
  localparam logic [addr_src_width-1:0] addr_src_jump        = 3'd5;

  localparam logic [addr_width-1:0] reset_address = 16'hFFFC;

endpackage : cpu_pkg

// ==== src/cpu_ctrl_if.sv ====
`timescale 1ns/10ps

interface cpu_ctrl_if;

  // Strobes from the sequencer
  logic load_a_from_data;
  logic load_x_from_data;
  logic alu_index_x;
  logic alu_to_hold;
  logic hold_to_a;
  logic pc_increment;
  logic pc_low_from_data;
  logic pc_high_from_data;
  logic bus_read;
  logic bus_write;
  logic [cpu_pkg::addr_src_width-1:0] addr_src;

  // Values from the datapath
  logic [cpu_pkg::addr_width-1:0] pc_next;
  logic [cpu_pkg::data_width-1:0] pc_low;
  logic [cpu_pkg::data_width-1:0] hold;
  logic [cpu_pkg::data_width-1:0] accumulator;

  modport sequencer (
    output load_a_from_data, load_x_from_data, alu_index_x, alu_to_hold, hold_to_a,
    output pc_increment, pc_low_from_data, pc_high_from_data, bus_read, bus_write,
    output addr_src
  );

  modport datapath (
    input  load_a_from_data, load_x_from_data, alu_index_x, alu_to_hold, hold_to_a,
    input  pc_increment, pc_low_from_data, pc_high_from_data,
    output pc_next, pc_low, hold, accumulator
  );

  modport bus_driver (
    input addr_src, bus_read, bus_write, pc_next, pc_low, hold, accumulator
  );

endinterface : cpu_ctrl_if

// ==== src/cpu_step_timer.sv ====
`timescale 1ns/10ps

module cpu_step_timer #(
  parameter int unsigned clock_divide = 4
) (
  input  logic clock_i,
  input  logic reset_i,
  output logic step_o
);

  logic [$clog2(clock_divide)-1:0] count;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count  <= '0;
      step_o <= 1'b0;
    end else if (count == ($clog2(clock_divide))'(clock_divide - 1)) begin
      count  <= '0;
      step_o <= 1'b1;
    end else begin
      count  <= count + 1'b1;
      step_o <= 1'b0;
    end
  end

endmodule : cpu_step_timer

// ==== src/cpu_sequencer.sv ====
`timescale 1ns/10ps

module cpu_sequencer (
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  logic                          step_i,
  input  logic [cpu_pkg::data_width-1:0] data_i,
  input  logic                          data_valid_i,
  cpu_ctrl_if.sequencer                 ctrl
);

  logic [cpu_pkg::data_width-1:0]  opcode;
  logic [cpu_pkg::stage_width-1:0] stage;
  logic [cpu_pkg::stage_width-1:0] stage_next;
  logic                            capture_opcode;

  always_comb begin
    ctrl.load_a_from_data  = 1'b0;
    ctrl.load_x_from_data  = 1'b0;
    ctrl.alu_index_x       = 1'b0;
    ctrl.alu_to_hold       = 1'b0;
    ctrl.hold_to_a         = 1'b0;
    ctrl.pc_increment      = 1'b0;
    ctrl.pc_low_from_data  = 1'b0;
    ctrl.pc_high_from_data = 1'b0;
    // Every waiting stage sits on a read, so a stall leaves the bus as it is
    ctrl.bus_read          = 1'b1;
    ctrl.bus_write         = 1'b0;
    ctrl.addr_src          = cpu_pkg::addr_src_keep;
    capture_opcode         = 1'b0;
    stage_next             = stage;

    case (stage)
      cpu_pkg::stage_vector_low: begin
        if (data_valid_i) begin
          ctrl.pc_low_from_data = 1'b1;
          ctrl.addr_src         = cpu_pkg::addr_src_vector_high;
          stage_next            = cpu_pkg::stage_vector_high;
        end
      end

      cpu_pkg::stage_vector_high: begin
        if (data_valid_i) begin
          ctrl.pc_high_from_data = 1'b1;
          ctrl.addr_src          = cpu_pkg::addr_src_jump;
          stage_next             = cpu_pkg::stage_fetch;
        end
      end

      cpu_pkg::stage_fetch: begin
        if (data_valid_i) begin
          capture_opcode    = 1'b1;
          // Pending ADC result lands here
          ctrl.hold_to_a    = (opcode == cpu_pkg::op_adc_imm);
          ctrl.pc_increment = 1'b1;
          ctrl.addr_src     = cpu_pkg::addr_src_pc_next;
          stage_next        = cpu_pkg::stage_operand;
        end
      end

      cpu_pkg::stage_operand: begin
        case (opcode)
          cpu_pkg::op_nop: begin
            stage_next = cpu_pkg::stage_fetch;
          end
          cpu_pkg::op_lda_imm, cpu_pkg::op_ldx_imm, cpu_pkg::op_adc_imm: begin
            if (data_valid_i) begin
              ctrl.load_a_from_data = (opcode == cpu_pkg::op_lda_imm);
              ctrl.load_x_from_data = (opcode == cpu_pkg::op_ldx_imm);
              ctrl.alu_to_hold      = (opcode == cpu_pkg::op_adc_imm);
              ctrl.pc_increment     = 1'b1;
              ctrl.addr_src         = cpu_pkg::addr_src_pc_next;
              stage_next            = cpu_pkg::stage_fetch;
            end
          end
          cpu_pkg::op_lda_zp, cpu_pkg::op_ldx_zp, cpu_pkg::op_sta_zp: begin
            if (data_valid_i) begin
              ctrl.bus_write = (opcode == cpu_pkg::op_sta_zp);
              ctrl.bus_read  = (opcode != cpu_pkg::op_sta_zp);
              ctrl.addr_src  = cpu_pkg::addr_src_zp_data;
              stage_next     = cpu_pkg::stage_access;
            end
          end
          cpu_pkg::op_lda_zpx: begin
            if (data_valid_i) begin
              ctrl.alu_index_x = 1'b1;
              ctrl.alu_to_hold = 1'b1;
              stage_next       = cpu_pkg::stage_access;
            end
          end
          cpu_pkg::op_jmp_abs: begin
            if (data_valid_i) begin
              ctrl.pc_low_from_data = 1'b1;
              ctrl.addr_src         = cpu_pkg::addr_src_pc_next;
              stage_next            = cpu_pkg::stage_access;
            end
          end
          default: begin
          end
        endcase
      end

      cpu_pkg::stage_access: begin
        case (opcode)
          cpu_pkg::op_lda_zp, cpu_pkg::op_ldx_zp, cpu_pkg::op_sta_zp: begin
            ctrl.load_a_from_data = (opcode == cpu_pkg::op_lda_zp);
            ctrl.load_x_from_data = (opcode == cpu_pkg::op_ldx_zp);
            ctrl.pc_increment     = 1'b1;
            ctrl.addr_src         = cpu_pkg::addr_src_pc_next;
            stage_next            = cpu_pkg::stage_fetch;
          end
          cpu_pkg::op_lda_zpx: begin
            ctrl.addr_src = cpu_pkg::addr_src_zp_hold;
            stage_next    = cpu_pkg::stage_finish;
          end
          cpu_pkg::op_jmp_abs: begin
            if (data_valid_i) begin
              ctrl.pc_high_from_data = 1'b1;
              ctrl.addr_src          = cpu_pkg::addr_src_jump;
              stage_next             = cpu_pkg::stage_fetch;
            end
          end
          default: begin
          end
        endcase
      end

      cpu_pkg::stage_finish: begin
        if (opcode == cpu_pkg::op_lda_zpx) begin
          ctrl.load_a_from_data = 1'b1;
          ctrl.pc_increment     = 1'b1;
          ctrl.addr_src         = cpu_pkg::addr_src_pc_next;
          stage_next            = cpu_pkg::stage_fetch;
        end
      end

      default: begin
      end
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage  <= cpu_pkg::stage_vector_low;
      opcode <= cpu_pkg::op_nop;
    end else if (step_i) begin
      stage <= stage_next;
      if (capture_opcode) begin
        opcode <= data_i;
      end
    end
  end

endmodule : cpu_sequencer

// ==== src/cpu_datapath.sv ====
`timescale 1ns/10ps

module cpu_datapath (
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  logic                          step_i,
  input  logic [cpu_pkg::data_width-1:0] data_i,
  cpu_ctrl_if.datapath                  ctrl
);

  logic [cpu_pkg::data_width-1:0] accumulator;
  logic [cpu_pkg::data_width-1:0] index_x;
  logic [cpu_pkg::data_width-1:0] adder_hold;
  logic [cpu_pkg::addr_width-1:0] program_counter;
  logic [cpu_pkg::data_width-1:0] alu_operand;
  logic [cpu_pkg::data_width-1:0] alu_sum;

  // Plain add, wraps at 256 and has no carry in
  assign alu_operand = ctrl.alu_index_x ? index_x : accumulator;
  assign alu_sum     = alu_operand + data_i;

  assign ctrl.pc_next     = program_counter + 1'b1;
  assign ctrl.pc_low      = program_counter[cpu_pkg::data_width-1:0];
  assign ctrl.hold        = adder_hold;
  assign ctrl.accumulator = accumulator;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      accumulator <= '0;
      index_x     <= '0;
    end else if (step_i) begin
      if (ctrl.load_a_from_data) begin
        accumulator <= data_i;
      end else if (ctrl.hold_to_a) begin
        accumulator <= adder_hold;
      end
      if (ctrl.load_x_from_data) begin
        index_x <= data_i;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (step_i) begin
      if (ctrl.pc_increment) begin
        program_counter <= ctrl.pc_next;
      end
      if (ctrl.pc_low_from_data) begin
        program_counter[cpu_pkg::data_width-1:0] <= data_i;
      end
      if (ctrl.pc_high_from_data) begin
        program_counter[cpu_pkg::addr_width-1:cpu_pkg::data_width] <= data_i;
      end
      if (ctrl.alu_to_hold) begin
        adder_hold <= alu_sum;
      end
    end
  end

endmodule : cpu_datapath

// ==== src/cpu_bus_driver.sv ====
`timescale 1ns/10ps

module cpu_bus_driver (
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  logic                          step_i,
  input  logic [cpu_pkg::data_width-1:0] data_i,
  cpu_ctrl_if.bus_driver                ctrl,
  output logic [cpu_pkg::addr_width-1:0] address_o,
  output logic [cpu_pkg::data_width-1:0] data_o,
  output logic                          bus_read_o,
  output logic                          bus_write_o
);

  logic [cpu_pkg::addr_width-1:0] address_next;

  always_comb begin
    case (ctrl.addr_src)
      cpu_pkg::addr_src_pc_next: address_next = ctrl.pc_next;
      cpu_pkg::addr_src_zp_data: begin
        address_next = {{(cpu_pkg::addr_width - cpu_pkg::data_width){1'b0}}, data_i};
      end
      cpu_pkg::addr_src_zp_hold: begin
        address_next = {{(cpu_pkg::addr_width - cpu_pkg::data_width){1'b0}}, ctrl.hold};
      end
      cpu_pkg::addr_src_vector_high: address_next = cpu_pkg::reset_address + 1'b1;
      // High byte arrives on the bus, low byte already sits in the PC
      cpu_pkg::addr_src_jump:        address_next = {data_i, ctrl.pc_low};
      default:                       address_next = address_o;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      address_o   <= cpu_pkg::reset_address;
      data_o      <= '0;
      bus_read_o  <= 1'b1;
      bus_write_o <= 1'b0;
    end else if (step_i) begin
      address_o   <= address_next;
      bus_read_o  <= ctrl.bus_read;
      bus_write_o <= ctrl.bus_write;
      if (ctrl.bus_write) begin
        data_o <= ctrl.accumulator;
      end
    end
  end

endmodule : cpu_bus_driver

// ==== src/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core #(
  parameter int unsigned clock_divide = 4
) (
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  logic [cpu_pkg::data_width-1:0] data_i,
  input  logic                          data_valid_i,
  output logic [cpu_pkg::data_width-1:0] data_o,
  output logic [cpu_pkg::addr_width-1:0] address_o,
  output logic                          bus_read_o,
  output logic                          bus_write_o
);

  logic step;

  cpu_ctrl_if ctrl ();

  cpu_step_timer #(
    .clock_divide(clock_divide)
  ) i_cpu_step_timer (
    .clock_i(clock_i),
    .reset_i(reset_i),
    .step_o (step)
  );

  cpu_sequencer i_cpu_sequencer (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .step_i      (step),
    .data_i      (data_i),
    .data_valid_i(data_valid_i),
    .ctrl        (ctrl.sequencer)
  );

  cpu_datapath i_cpu_datapath (
    .clock_i(clock_i),
    .reset_i(reset_i),
    .step_i (step),
    .data_i (data_i),
    .ctrl   (ctrl.datapath)
  );

  cpu_bus_driver i_cpu_bus_driver (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .step_i     (step),
    .data_i     (data_i),
    .ctrl       (ctrl.bus_driver),
    .address_o  (address_o),
    .data_o     (data_o),
    .bus_read_o (bus_read_o),
    .bus_write_o(bus_write_o)
  );

endmodule : cpu_core

// ==== bench/cpu_core_assertions.sv ====
`timescale 1ns/10ps

module cpu_core_assertions (
  input logic                           clock_i,
  input logic                           reset_i,
  input logic [cpu_pkg::data_width-1:0] data_o,
  input logic                           bus_read_o,
  input logic                           bus_write_o
);

  int unsigned failure_count = 0;

  read_write_exclusive: assert property (
    @(posedge clock_i) disable iff (reset_i) !(bus_read_o && bus_write_o)
  ) else begin
    failure_count++;
    $error("bus_read_o and bus_write_o high together");
  end

  write_low_after_reset: assert property (
    @(posedge clock_i) reset_i |=> !bus_write_o
  ) else begin
    failure_count++;
    $error("bus_write_o high after reset");
  end

  // Store data holds for the whole write step
  write_data_stable: assert property (
    @(posedge clock_i) disable iff (reset_i)
    (bus_write_o && $past(bus_write_o)) |-> $stable(data_o)
  ) else begin
    failure_count++;
    $error("data_o changed during a write");
  end

endmodule : cpu_core_assertions

bind cpu_core cpu_core_assertions i_cpu_core_assertions (
  .clock_i    (clock_i),
  .reset_i    (reset_i),
  .data_o     (data_o),
  .bus_read_o (bus_read_o),
  .bus_write_o(bus_write_o)
);

// ==== bench/cpu_core_tb.sv ====
`timescale 1ns/10ps

module cpu_core_tb;

  localparam int unsigned clock_divide = 3;
  localparam int unsigned run_timeout  = 4000;
  localparam logic [cpu_pkg::addr_width-1:0] end_address = 16'h3000;
  localparam logic [cpu_pkg::addr_width-1:0] main_base   = 16'h0200;
  localparam logic [cpu_pkg::addr_width-1:0] vector_high = cpu_pkg::reset_address + 16'd1;

  logic                           clock;
  logic                           reset        = 1'b1;
  logic [cpu_pkg::data_width-1:0] data         = '0;
  logic                           data_valid   = 1'b1;
  logic [cpu_pkg::data_width-1:0] data_out;
  logic [cpu_pkg::addr_width-1:0] address;
  logic                           bus_read;
  logic                           bus_write;
  logic                           stall_enable = 1'b0;
  logic [31:0]                    random_state = 32'h143a_7427;
  logic [cpu_pkg::addr_width-1:0] load_pointer;
  logic [cpu_pkg::data_width-1:0] memory [0:(1 << cpu_pkg::addr_width) - 1];

  // Bus history, one entry per change of address or write strobe
  logic [cpu_pkg::addr_width-1:0] read_log[$];
  logic [cpu_pkg::addr_width-1:0] write_address_log[$];
  logic [cpu_pkg::data_width-1:0] write_data_log[$];
  logic [cpu_pkg::addr_width-1:0] saved_read_log[$];
  logic [cpu_pkg::addr_width-1:0] saved_write_address_log[$];
  logic [cpu_pkg::data_width-1:0] saved_write_data_log[$];
  logic [cpu_pkg::addr_width-1:0] expected_address[$];
  logic [cpu_pkg::data_width-1:0] expected_data[$];
  logic [cpu_pkg::addr_width-1:0] last_address;
  logic                           last_write;
  logic                           log_started;

  cpu_core #(
    .clock_divide(clock_divide)
  ) i_cpu_core (
    .clock_i     (clock),
    .reset_i     (reset),
    .data_i      (data),
    .data_valid_i(data_valid),
    .data_o      (data_out),
    .address_o   (address),
    .bus_read_o  (bus_read),
    .bus_write_o (bus_write)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Read side of the memory, one clock behind the address
  always @(posedge clock) begin
    data <= memory[address];
  end

  always @(posedge clock) begin
    if (stall_enable) begin
      random_state <= next_random(random_state);
      data_valid   <= random_state[7];
    end else begin
      data_valid <= 1'b1;
    end
  end

  // The bound checker counts failed bus properties
  always @(posedge clock) begin
    if (i_cpu_core.i_cpu_core_assertions.failure_count != 0) begin
      abort_run("A bus property check failed");
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] value;
    value = state ^ (state << 13);
    value = value ^ (value >> 17);
    value = value ^ (value << 5);
    return value;
  endfunction

  function automatic logic [cpu_pkg::data_width-1:0] fill_value(
    input logic [cpu_pkg::addr_width-1:0] location
  );
    return (location[7:0] ^ 8'h96) + (location[15:8] * 8'd37);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_address(input string name,
                               input logic [cpu_pkg::addr_width-1:0] actual,
                               input logic [cpu_pkg::addr_width-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected));
    end
  endtask

  task automatic check_byte(input string name,
                            input logic [cpu_pkg::data_width-1:0] actual,
                            input logic [cpu_pkg::data_width-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected));
    end
  endtask

  task automatic begin_program(input logic [cpu_pkg::addr_width-1:0] base);
    logic [cpu_pkg::addr_width-1:0] location;
    location = '0;
    repeat (1 << cpu_pkg::addr_width) begin
      memory[location] = fill_value(location);
      location = location + 16'd1;
    end
    memory[cpu_pkg::reset_address] = base[7:0];
    memory[vector_high]            = base[15:8];
    memory[end_address]            = cpu_pkg::op_nop;
    load_pointer = base;
  endtask

  task automatic emit(input logic [cpu_pkg::data_width-1:0] value);
    memory[load_pointer] = value;
    load_pointer = load_pointer + 16'd1;
  endtask

  task automatic emit_instruction(input logic [cpu_pkg::data_width-1:0] opcode,
                                  input logic [cpu_pkg::data_width-1:0] operand);
    emit(opcode);
    emit(operand);
  endtask

  task automatic emit_jump(input logic [cpu_pkg::addr_width-1:0] target);
    emit(cpu_pkg::op_jmp_abs);
    emit(target[7:0]);
    emit(target[15:8]);
  endtask

  task automatic expect_write(input logic [cpu_pkg::addr_width-1:0] location,
                              input logic [cpu_pkg::data_width-1:0] value);
    expected_address.push_back(location);
    expected_data.push_back(value);
  endtask

  // Leaves reset high and returns on a falling edge
  task automatic hold_reset(input logic with_stalls);
    @(posedge clock);
    reset        <= 1'b1;
    stall_enable <= with_stalls;
    repeat (4) @(posedge clock);
    @(negedge clock);
    read_log.delete();
    write_address_log.delete();
    write_data_log.delete();
    expected_address.delete();
    expected_data.delete();
    log_started = 1'b0;
  endtask

  task automatic record_bus();
    if (bus_write) begin
      memory[address] = data_out;
    end
    if (!log_started || address != last_address || bus_write != last_write) begin
      if (bus_write) begin
        write_address_log.push_back(address);
        write_data_log.push_back(data_out);
      end else if (bus_read) begin
        read_log.push_back(address);
      end
      last_address = address;
      last_write   = bus_write;
      log_started  = 1'b1;
    end
  endtask

  task automatic run_to_end();
    int unsigned clocks;
    clocks = 0;
    @(posedge clock);
    reset <= 1'b0;
    do begin
      @(negedge clock);
      record_bus();
      clocks++;
      if (clocks > run_timeout) begin
        abort_run("Timed out before the program reached its final fetch");
      end
    end while (!(bus_read && address == end_address));
  endtask

  task automatic check_read_after(input logic [cpu_pkg::addr_width-1:0] prior,
                                  input logic [cpu_pkg::addr_width-1:0] expected);
    int index;
    index = -1;
    foreach (read_log[i]) begin
      if (index < 0 && read_log[i] == prior) begin
        index = i;
      end
    end
    if (index < 0 || index + 1 >= read_log.size()) begin
      abort_run($sformatf("No read followed a read at address %h", prior));
    end else begin
      check_address("address_o", read_log[index + 1], expected);
    end
  endtask

  task automatic check_write_log();
    if (write_address_log.size() != expected_address.size()) begin
      abort_run($sformatf("Saw %0d writes where %0d were expected",
                          write_address_log.size(), expected_address.size()));
    end
    foreach (expected_address[i]) begin
      check_address("address_o on write", write_address_log[i], expected_address[i]);
      check_byte("data_o on write", write_data_log[i], expected_data[i]);
    end
  endtask

  task automatic keep_logs();
    saved_read_log          = read_log;
    saved_write_address_log = write_address_log;
    saved_write_data_log    = write_data_log;
  endtask

  task automatic compare_logs();
    if (read_log.size() != saved_read_log.size() ||
        write_address_log.size() != saved_write_address_log.size()) begin
      abort_run("The stalled run left a bus history of a different length");
    end
    foreach (saved_read_log[i]) begin
      check_address("address_o on read", read_log[i], saved_read_log[i]);
    end
    foreach (saved_write_address_log[i]) begin
      check_address("address_o on write", write_address_log[i], saved_write_address_log[i]);
      check_byte("data_o on write", write_data_log[i], saved_write_data_log[i]);
    end
  endtask

  task automatic test_reset_vector();
    hold_reset(1'b0);
    begin_program(16'h1234);
    // A is still zero from reset
    emit_instruction(cpu_pkg::op_sta_zp, 8'h50);
    emit_jump(end_address);
    expect_write(16'h0050, 8'h00);
    check_address("address_o", address, cpu_pkg::reset_address);
    check_bit("bus_read_o", bus_read, 1'b1);
    check_bit("bus_write_o", bus_write, 1'b0);
    check_byte("data_o", data_out, 8'h00);
    run_to_end();
    check_address("address_o", read_log[0], cpu_pkg::reset_address);
    check_read_after(cpu_pkg::reset_address, vector_high);
    check_read_after(vector_high, 16'h1234);
    check_write_log();
  endtask

  task automatic test_loads_and_store(input logic with_stalls);
    hold_reset(with_stalls);
    begin_program(main_base);
    emit_instruction(cpu_pkg::op_lda_imm, 8'h3C);
    emit_instruction(cpu_pkg::op_sta_zp, 8'h40);
    emit_instruction(cpu_pkg::op_lda_zp, 8'h43);
    emit_instruction(cpu_pkg::op_sta_zp, 8'h41);
    emit_instruction(cpu_pkg::op_ldx_imm, 8'h25);
    emit_instruction(cpu_pkg::op_lda_zpx, 8'hF0);
    emit_instruction(cpu_pkg::op_sta_zp, 8'h42);
    emit_jump(end_address);
    expect_write(16'h0040, 8'h3C);
    // Zero page 43 still holds its fill byte
    expect_write(16'h0041, fill_value(16'h0043));
    // F0 plus 25 wraps to 15 in page zero
    expect_write(16'h0042, fill_value(16'h0015));
    run_to_end();
    check_read_after(16'h020B, 16'h0015);
    check_write_log();
  endtask

  task automatic test_add(input logic with_stalls);
    logic [cpu_pkg::data_width-1:0] first;
    logic [cpu_pkg::data_width-1:0] second;
    logic [cpu_pkg::data_width-1:0] sum;
    first  = 8'hC8;
    second = 8'h5D;
    // C8 plus 5D wraps to 25
    sum    = 8'h25;
    hold_reset(with_stalls);
    begin_program(main_base);
    emit_instruction(cpu_pkg::op_lda_imm, first);
    emit_instruction(cpu_pkg::op_adc_imm, second);
    emit_instruction(cpu_pkg::op_sta_zp, 8'h60);
    emit_jump(end_address);
    expect_write(16'h0060, sum);
    run_to_end();
    check_write_log();
  endtask

  task automatic test_jump(input logic with_stalls);
    hold_reset(with_stalls);
    begin_program(main_base);
    emit(cpu_pkg::op_nop);
    emit_jump(16'h4567);
    load_pointer = 16'h4567;
    emit_instruction(cpu_pkg::op_lda_imm, 8'h5E);
    emit_instruction(cpu_pkg::op_sta_zp, 8'h71);
    emit_jump(end_address);
    expect_write(16'h0071, 8'h5E);
    run_to_end();
    check_read_after(16'h0201, 16'h0202);
    check_read_after(16'h0203, 16'h4567);
    check_write_log();
  endtask

  // Each program runs once with data always valid and once with random stalls
  task automatic test_stalls();
    test_loads_and_store(1'b0);
    keep_logs();
    test_loads_and_store(1'b1);
    compare_logs();
    test_add(1'b0);
    keep_logs();
    test_add(1'b1);
    compare_logs();
    test_jump(1'b0);
    keep_logs();
    test_jump(1'b1);
    compare_logs();
  endtask

  initial begin
    test_reset_vector();
    test_stalls();
    if (i_cpu_core.i_cpu_core_assertions.failure_count != 0) begin
      $display("Bus property checks failed during the run");
      $display("RESULT: FAIL");
      $fatal(1, "Run stopped");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule : cpu_core_tb

// ==== cpu.f ====
src/cpu_pkg.sv
src/cpu_ctrl_if.sv
src/cpu_step_timer.sv
src/cpu_sequencer.sv
src/cpu_datapath.sv
src/cpu_bus_driver.sv
src/cpu_core.sv
bench/cpu_core_assertions.sv
bench/cpu_core_tb.sv

// ==== Makefile ====
VERILATOR       ?= verilator
TOP             ?= cpu_core_tb
FILE_LIST       ?= cpu.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --sv --timing --assert
LINT_FLAGS      ?= --lint-only

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

$(BUILD_DIR)/$(TOP): $(FILE_LIST)
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
